/* updi_programmer.f */
hw/updi_proto_pkg.sv
hw/updi_prog_pkg.sv
hw/updi_delay_timer.sv
hw/updi_frame_builder.sv
hw/updi_reply_collector.sv
hw/updi_sequencer.sv
hw/updi_programmer.sv
bench/updi_programmer_props.sv
bench/tb_updi_programmer.sv

/* Bender.yml */
package:
  name: updi_programmer

sources:
  - files:
      - hw/updi_proto_pkg.sv
      - hw/updi_prog_pkg.sv
      - hw/updi_delay_timer.sv
      - hw/updi_frame_builder.sv
      - hw/updi_reply_collector.sv
      - hw/updi_sequencer.sv
      - hw/updi_programmer.sv
  - target: simulation
    files:
      - bench/updi_programmer_props.sv
      - bench/tb_updi_programmer.sv

/* bench/tb_updi_programmer.sv */
// testbench for the UPDI programmer with a target model, a reference byte list, stimulus and checks
`timescale 1ns/1ps

module tb_updi_programmer;

	import updi_proto_pkg::*;
	import updi_prog_pkg::*;

	localparam int SESSIONS = 7;
	// SYS_STATUS answers of the target model
	localparam byte_t SYS_LOCKED = byte_t'(1 << SYS_STATUS_LOCKED);
	localparam byte_t SYS_OPEN = byte_t'(1 << SYS_STATUS_NVMPROG);

	logic clk = 1'b0;
	logic rst;
	logic start;
	logic busy;
	logic done;
	logic failed;
	fail_code_t fail_code;
	device_id_t device_id;
	byte_t tx_data;
	logic tx_wr_en;
	logic tx_full;
	byte_t rx_data;
	logic rx_rd_en;
	logic rx_empty;
	logic double_break_start;
	logic double_break_done;

	// model settings of the running session
	byte_t cfg_statusa;
	byte_t cfg_key_status;
	int cfg_locked_polls;
	logic cfg_ack_ok;
	logic cfg_backpressure;
	device_id_t cfg_sig;

	byte_t exp_q[$];
	fail_code_t exp_code;
	int exp_frames;
	int tx_idx;
	int checks_done;
	logic [31:0] lfsr_state = 32'hd42c_70fa;
	int unsigned cyc = 0;
	int unsigned deadline;
	logic watch_en = 1'b0;

	// target model state
	byte_t reply_q[$];
	byte_t rx_fifo[$];
	logic in_frame;
	byte_t opcode;
	int ops_left;
	int rpt;
	int polls_left;
	int brk_cnt;

	updi_programmer u_updi_programmer (
		.clk                (clk),
		.rst                (rst),
		.start              (start),
		.busy               (busy),
		.done               (done),
		.failed             (failed),
		.fail_code          (fail_code),
		.device_id          (device_id),
		.tx_data            (tx_data),
		.tx_wr_en           (tx_wr_en),
		.tx_full            (tx_full),
		.rx_data            (rx_data),
		.rx_rd_en           (rx_rd_en),
		.rx_empty           (rx_empty),
		.double_break_start (double_break_start),
		.double_break_done  (double_break_done)
	);

	always #10 clk = ~clk;

	task automatic end_with_failure();
		$display("Test failures found");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic fail_run(string why);
		$display("ERROR at %0t ns: %s", $time, why);
		end_with_failure();
	endtask

	task automatic mismatch(string sig, logic [31:0] exp_val, logic [31:0] got_val);
		$display("[FAIL] %0t ns: %s expected %0h, got %0h", $time, sig, exp_val, got_val);
		end_with_failure();
	endtask

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic next_bit();
		lfsr_state = lfsr_step(lfsr_state);
		return lfsr_state[0];
	endfunction

	// SYNC, opcode, then n operand bytes taken from the top of operands
	function automatic void expect_frame(byte_t op, int n, logic [63:0] operands);
		int i;
		exp_q.push_back(SYNC_BYTE);
		exp_q.push_back(op);
		for (i = 0; i < n; i++) begin
			exp_q.push_back(operands[63 - 8 * i -: 8]);
		end
		exp_frames++;
	endfunction

	// phase 0 waits for the lock to clear, phase 1 for NVM programming mode
	function automatic logic unlocked(int phase, byte_t status);
		return (phase == 0) ? !status[SYS_STATUS_LOCKED] : status[SYS_STATUS_NVMPROG];
	endfunction

	// expected TX byte list and outcome of one session
	function automatic void build_reference();
		int phase;
		int checks;
		int locked_left;
		byte_t last_status;
		logic ready;
		exp_q.delete();
		exp_frames = 0;
		exp_code = FAIL_NONE;
		locked_left = cfg_locked_polls;
		expect_frame(OP_LDCS | byte_t'(CS_STATUSA), 0, '0);
		if (cfg_statusa == 8'h00) begin
			exp_code = FAIL_STATUSA;
			return;
		end
		for (phase = 0; phase < 2; phase++) begin
			expect_frame(OP_KEY64, 8, (phase == 0) ? KEY_CHIPERASE : KEY_NVMPROG);
			expect_frame(OP_LDCS | byte_t'(CS_KEY_STATUS), 0, '0);
			if (!cfg_key_status[(phase == 0) ? KEY_STATUS_CHIPERASE : KEY_STATUS_NVMPROG]) begin
				exp_code = (phase == 0) ? FAIL_KEY_CHIPERASE : FAIL_KEY_NVMPROG;
				return;
			end
			expect_frame(OP_STCS | byte_t'(CS_RESET_REQ), 1, {RESET_SIGNATURE, 56'h0});
			expect_frame(OP_STCS | byte_t'(CS_RESET_REQ), 1, 64'h0);
			checks = 0;
			ready = 1'b0;
			while (!ready && checks < POLL_LIMIT) begin
				expect_frame(OP_LDCS | byte_t'(CS_SYS_STATUS), 0, '0);
				last_status = (locked_left > 0) ? SYS_LOCKED : SYS_OPEN;
				if (locked_left > 0) begin
					locked_left--;
				end
				checks++;
				ready = unlocked(phase, last_status);
			end
			if (!ready) begin
				exp_code = FAIL_POLL_TIMEOUT;
				return;
			end
		end
		expect_frame(OP_ST_PTR_WORD, 2, {SIG_BASE_ADDR[7:0], SIG_BASE_ADDR[15:8], 48'h0});
		if (!cfg_ack_ok) begin
			exp_code = FAIL_NO_ACK;
			return;
		end
		expect_frame(OP_REPEAT_BYTE, 1, {8'(DEVICE_ID_BYTES - 1), 56'h0});
		expect_frame(OP_LD_PTR_INC_BYTE, 0, '0);
	endfunction

	// target model decoding written frames, answering through the RX FIFO and throttling TX
	always @(posedge clk) begin
		byte_t b;
		logic b0;
		logic b1;
		int i;
		if (rst) begin
			reply_q.delete();
			rx_fifo.delete();
			in_frame = 1'b0;
			ops_left = 0;
			rpt = 1;
			polls_left = cfg_locked_polls;
			brk_cnt = 0;
			tx_full <= 1'b0;
			rx_empty <= 1'b1;
			rx_data <= 8'h00;
			double_break_done <= 1'b0;
		end else begin
			double_break_done <= (brk_cnt == 1);
			if (brk_cnt > 0) begin
				brk_cnt--;
			end
			if (double_break_start) begin
				brk_cnt = 6;
			end
			if (tx_wr_en && !tx_full) begin
				b = tx_data;
				if (ops_left > 0) begin
					ops_left--;
					if (opcode == OP_REPEAT_BYTE) begin
						rpt = int'(b) + 1;
					end
					if (opcode == OP_ST_PTR_WORD && ops_left == 0) begin
						reply_q.push_back(cfg_ack_ok ? ACK_BYTE : 8'h00);
					end
				end else if (!in_frame) begin
					in_frame = (b == SYNC_BYTE);
				end else begin
					in_frame = 1'b0;
					opcode = b;
					if (b[7:4] == OP_LDCS[7:4]) begin
						case (b[3:0])
							CS_STATUSA: reply_q.push_back(cfg_statusa);
							CS_KEY_STATUS: reply_q.push_back(cfg_key_status);
							CS_SYS_STATUS: begin
								reply_q.push_back((polls_left > 0) ? SYS_LOCKED : SYS_OPEN);
								if (polls_left > 0) begin
									polls_left--;
								end
							end
							default: reply_q.push_back(8'h00);
						endcase
					end else if (b[7:4] == OP_STCS[7:4]) begin
						ops_left = 1;
					end else if (b == OP_KEY64) begin
						ops_left = 8;
					end else if (b == OP_ST_PTR_WORD) begin
						ops_left = 2;
					end else if (b == OP_REPEAT_BYTE) begin
						ops_left = 1;
					end else if (b == OP_LD_PTR_INC_BYTE) begin
						// signature goes out top byte first
						for (i = 0; i < rpt && i < DEVICE_ID_BYTES; i++) begin
							reply_q.push_back(cfg_sig[8 * (DEVICE_ID_BYTES - 1 - i) +: 8]);
						end
						rpt = 1;
					end
				end
			end
			// popped byte shows on rx_data one cycle after the read
			if (rx_rd_en && rx_fifo.size() > 0) begin
				rx_data <= rx_fifo.pop_front();
			end
			if (reply_q.size() > 0) begin
				if (next_bit()) begin
					rx_fifo.push_back(reply_q.pop_front());
				end
			end
			rx_empty <= (rx_fifo.size() == 0);
			if (cfg_backpressure) begin
				b0 = next_bit();
				b1 = next_bit();
				tx_full <= b0 && b1;
			end else begin
				tx_full <= 1'b0;
			end
		end
	end

	// compare each accepted TX byte against the reference list
	always @(posedge clk) begin
		if (!rst) begin
			assert (!(tx_wr_en && tx_full))
				else fail_run("tx_wr_en high while tx_full is high");
			assert (!(rx_rd_en && rx_empty))
				else fail_run("rx_rd_en high while rx_empty is high");
			assert (!(done && failed))
				else fail_run("done and failed are high together");
			if (tx_wr_en && !tx_full) begin
				assert (tx_idx < exp_q.size())
					else fail_run($sformatf("unexpected extra byte %02h on the TX FIFO", tx_data));
				assert (tx_data == exp_q[tx_idx])
					else mismatch($sformatf("tx_data[%0d]", tx_idx), exp_q[tx_idx], tx_data);
				tx_idx++;
			end
		end
	end

	// cycle budget of a session comes from its frame count
	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (watch_en && cyc > deadline) begin
			fail_run("watchdog expired before the session finished");
		end
	end

	task automatic run_session(string name, byte_t statusa, byte_t key_status, int locked,
		logic ack_ok, logic backpressure, device_id_t sig);
		cfg_statusa = statusa;
		cfg_key_status = key_status;
		cfg_locked_polls = locked;
		cfg_ack_ok = ack_ok;
		cfg_backpressure = backpressure;
		cfg_sig = sig;
		build_reference();
		@(posedge clk);
		rst <= 1'b1;
		start <= 1'b0;
		repeat (3) @(posedge clk);
		tx_idx = 0;
		deadline = cyc + exp_frames * 200;
		watch_en = 1'b1;
		rst <= 1'b0;
		@(negedge clk);
		assert (!(busy || done || failed || tx_wr_en || rx_rd_en || double_break_start))
			else fail_run($sformatf("%s: an output is not low right after reset", name));
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		do begin
			@(negedge clk);
		end while (!(done || failed));
		assert (!busy) else fail_run($sformatf("%s: busy still high at the end", name));
		assert (fail_code == exp_code) else mismatch("fail_code", exp_code, fail_code);
		assert (done == (exp_code == FAIL_NONE)) else mismatch("done", exp_code == FAIL_NONE, done);
		if (exp_code == FAIL_NONE) begin
			assert (device_id == cfg_sig) else mismatch("device_id", cfg_sig, device_id);
		end
		// quiet window so that any byte after the last expected frame is caught
		repeat (20) @(negedge clk);
		assert (tx_idx == exp_q.size()) else mismatch("tx byte count", exp_q.size(), tx_idx);
		assert (done == (exp_code == FAIL_NONE) && failed == (exp_code != FAIL_NONE))
			else fail_run($sformatf("%s: done or failed not held after the session", name));
		assert (fail_code == exp_code) else mismatch("fail_code held", exp_code, fail_code);
		if (exp_code == FAIL_NONE) begin
			assert (device_id == cfg_sig) else mismatch("device_id held", cfg_sig, device_id);
		end
		watch_en = 1'b0;
		checks_done++;
		$display("session %s: %0d bytes, fail_code %0d", name, tx_idx, fail_code);
	endtask

	initial begin
		rst = 1'b1;
		start = 1'b0;
		tx_full = 1'b0;
		rx_empty = 1'b1;
		rx_data = 8'h00;
		double_break_done = 1'b0;
		checks_done = 0;
		tx_idx = 0;
		run_session("nominal", 8'h30, 8'h18, 0, 1'b1, 1'b0, 24'h1E9653);
		run_session("locked polls", 8'h30, 8'h19, 3, 1'b1, 1'b0, 24'h1E9551);
		run_session("poll timeout", 8'h30, 8'h19, POLL_LIMIT, 1'b1, 1'b0, 24'h1E9551);
		run_session("statusa zero", 8'h00, 8'h18, 0, 1'b1, 1'b0, 24'h1E9653);
		run_session("no chip erase key", 8'h30, 8'h10, 0, 1'b1, 1'b0, 24'h1E9653);
		run_session("bad ack", 8'h30, 8'h18, 0, 1'b0, 1'b0, 24'h1E9653);
		run_session("backpressure", 8'h30, 8'h19, 2, 1'b1, 1'b1, 24'h1E950F);
		if (checks_done == SESSIONS) begin
			$display("All tests passed!");
			$finish;
		end else begin
			fail_run("not every session completed its checks");
		end
	end

endmodule

/* bench/updi_programmer_props.sv */
// concurrent handshake and flag properties, bound into the UPDI programmer top
`timescale 1ns/1ps

module updi_programmer_props (
	input logic clk,
	input logic rst,
	input logic busy,
	input logic done,
	input logic failed,
	input logic tx_wr_en,
	input logic tx_full,
	input logic rx_rd_en,
	input logic rx_empty,
	input logic double_break_start
);

	tx_write_respects_full: assert property (@(posedge clk) disable iff (rst)
		tx_wr_en |-> !tx_full)
		else $error("tx_wr_en raised while the TX FIFO is full");

	rx_read_respects_empty: assert property (@(posedge clk) disable iff (rst)
		rx_rd_en |-> !rx_empty)
		else $error("rx_rd_en raised while the RX FIFO is empty");

	flags_exclusive: assert property (@(posedge clk) disable iff (rst)
		!(done && failed))
		else $error("done and failed high together");

	break_start_one_cycle: assert property (@(posedge clk) disable iff (rst)
		double_break_start |=> !double_break_start)
		else $error("double_break_start longer than one cycle");

	// busy drops in the cycle the result flag rises
	busy_ends_with_result: assert property (@(posedge clk) disable iff (rst)
		($rose(done) || $rose(failed)) |-> !busy)
		else $error("busy still high when the session result appeared");

endmodule

bind updi_programmer updi_programmer_props u_props (
	.clk                (clk),
	.rst                (rst),
	.busy               (busy),
	.done               (done),
	.failed             (failed),
	.tx_wr_en           (tx_wr_en),
	.tx_full            (tx_full),
	.rx_rd_en           (rx_rd_en),
	.rx_empty           (rx_empty),
	.double_break_start (double_break_start)
);

/* hw/updi_programmer.sv */
// UPDI programmer top: connects the session FSM to the frame builder, reply collector and timer
`timescale 1ns/1ps

module updi_programmer (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      start,
	output logic                      busy,
	output logic                      done,
	output logic                      failed,
	output updi_prog_pkg::fail_code_t fail_code,
	output updi_prog_pkg::device_id_t device_id,
	output updi_proto_pkg::byte_t     tx_data,
	output logic                      tx_wr_en,
	input  logic                      tx_full,
	input  updi_proto_pkg::byte_t     rx_data,
	output logic                      rx_rd_en,
	input  logic                      rx_empty,
	output logic                      double_break_start,
	input  logic                      double_break_done
);

	import updi_prog_pkg::*;

	logic frame_start;
	logic frame_busy;
	frame_kind_t frame_kind;
	cs_addr_t frame_cs_addr;

	logic reply_start;
	logic reply_done;
	logic reply_ack_ok;
	logic reply_ack_only;
	reply_len_t reply_len;
	device_id_t reply_bytes;

	logic delay_start;
	logic delay_done;
	delay_cnt_t delay_clks;

	updi_sequencer u_sequencer (
		.clk                (clk),
		.rst                (rst),
		.start              (start),
		.double_break_done  (double_break_done),
		.frame_busy         (frame_busy),
		.reply_done         (reply_done),
		.reply_ack_ok       (reply_ack_ok),
		.reply_bytes        (reply_bytes),
		.delay_done         (delay_done),
		.busy               (busy),
		.done               (done),
		.failed             (failed),
		.fail_code          (fail_code),
		.device_id          (device_id),
		.double_break_start (double_break_start),
		.frame_start        (frame_start),
		.frame_kind         (frame_kind),
		.frame_cs_addr      (frame_cs_addr),
		.reply_start        (reply_start),
		.reply_len          (reply_len),
		.reply_ack_only     (reply_ack_only),
		.delay_start        (delay_start),
		.delay_clks         (delay_clks)
	);

	updi_delay_timer u_delay_timer (
		.clk         (clk),
		.rst         (rst),
		.delay_start (delay_start),
		.delay_clks  (delay_clks),
		.delay_done  (delay_done)
	);

	updi_frame_builder u_frame_builder (
		.clk           (clk),
		.rst           (rst),
		.frame_start   (frame_start),
		.frame_kind    (frame_kind),
		.frame_cs_addr (frame_cs_addr),
		.frame_busy    (frame_busy),
		.tx_data       (tx_data),
		.tx_wr_en      (tx_wr_en),
		.tx_full       (tx_full)
	);

	updi_reply_collector u_reply_collector (
		.clk            (clk),
		.rst            (rst),
		.reply_start    (reply_start),
		.reply_len      (reply_len),
		.reply_ack_only (reply_ack_only),
		.rx_data        (rx_data),
		.rx_rd_en       (rx_rd_en),
		.rx_empty       (rx_empty),
		.reply_done     (reply_done),
		.reply_ack_ok   (reply_ack_ok),
		.reply_bytes    (reply_bytes)
	);

endmodule

/* hw/updi_sequencer.sv */
// Session FSM that walks break, status check, key unlocks with reset and polling, then device ID read
`timescale 1ns/1ps

module updi_sequencer (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      start,
	input  logic                      double_break_done,
	input  logic                      frame_busy,
	input  logic                      reply_done,
	input  logic                      reply_ack_ok,
	input  updi_prog_pkg::device_id_t reply_bytes,
	input  logic                      delay_done,
	output logic                      busy,
	output logic                      done,
	output logic                      failed,
	output updi_prog_pkg::fail_code_t fail_code,
	output updi_prog_pkg::device_id_t device_id,
	output logic                      double_break_start,
	output logic                      frame_start,
	output updi_prog_pkg::frame_kind_t frame_kind,
	output updi_prog_pkg::cs_addr_t   frame_cs_addr,
	output logic                      reply_start,
	output updi_prog_pkg::reply_len_t reply_len,
	output logic                      reply_ack_only,
	output logic                      delay_start,
	output updi_prog_pkg::delay_cnt_t delay_clks
);

	import updi_proto_pkg::*;
	import updi_prog_pkg::*;

	localparam int POLL_CNT_W = $clog2(POLL_LIMIT);

	seq_state_t state;
	// state to resume once a frame or a delay has finished
	seq_state_t wait_ret;
	// low while unlocking chip erase, high while unlocking NVM programming
	logic nvm_phase;
	logic reply_pending;
	logic reply_seen;
	logic reply_ok_q;
	logic [POLL_CNT_W-1:0] poll_cnt;
	logic key_ok;
	logic poll_ready;
	logic poll_at_limit;

	assign key_ok = nvm_phase ? reply_bytes[KEY_STATUS_NVMPROG]
		: reply_bytes[KEY_STATUS_CHIPERASE];
	assign poll_ready = nvm_phase ? reply_bytes[SYS_STATUS_NVMPROG]
		: !reply_bytes[SYS_STATUS_LOCKED];
	assign poll_at_limit = (poll_cnt == POLL_CNT_W'(POLL_LIMIT - 1));

	// request decode where every issuing state lasts exactly one cycle
	always_comb begin
		double_break_start = 1'b0;
		frame_start = 1'b0;
		frame_kind = FRAME_LDCS;
		frame_cs_addr = CS_STATUSA;
		reply_start = 1'b0;
		reply_len = 2'd1;
		reply_ack_only = 1'b0;
		delay_start = 1'b0;
		delay_clks = POLL_DELAY_CLKS;
		case (state)
			S_BREAK: begin
				double_break_start = 1'b1;
			end
			S_STATUSA, S_KEY_STATUS, S_POLL: begin
				frame_start = 1'b1;
				frame_kind = FRAME_LDCS;
				if (state == S_STATUSA) begin
					frame_cs_addr = CS_STATUSA;
				end else if (state == S_KEY_STATUS) begin
					frame_cs_addr = CS_KEY_STATUS;
				end else begin
					frame_cs_addr = CS_SYS_STATUS;
				end
				reply_start = 1'b1;
			end
			S_KEY: begin
				frame_start = 1'b1;
				frame_kind = nvm_phase ? FRAME_KEY_NVMPROG : FRAME_KEY_CHIPERASE;
			end
			S_RESET_SET, S_RESET_CLEAR: begin
				frame_start = 1'b1;
				frame_kind = (state == S_RESET_SET) ? FRAME_STCS_RESET_SET
					: FRAME_STCS_RESET_CLEAR;
				frame_cs_addr = CS_RESET_REQ;
			end
			S_RESET_DELAY: begin
				delay_start = 1'b1;
				delay_clks = RESET_DELAY_CLKS;
			end
			S_POLL_CHECK: begin
				// wait before the next poll while still locked
				delay_start = !poll_ready && !poll_at_limit;
			end
			S_ID_PTR: begin
				frame_start = 1'b1;
				frame_kind = FRAME_ST_PTR;
				reply_start = 1'b1;
				reply_ack_only = 1'b1;
			end
			S_ID_REPEAT: begin
				frame_start = 1'b1;
				frame_kind = FRAME_REPEAT;
			end
			S_ID_LOAD: begin
				frame_start = 1'b1;
				frame_kind = FRAME_LD_INC;
				reply_start = 1'b1;
				reply_len = reply_len_t'(DEVICE_ID_BYTES);
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_IDLE;
			wait_ret <= S_IDLE;
			nvm_phase <= 1'b0;
			reply_pending <= 1'b0;
			reply_seen <= 1'b0;
			poll_cnt <= '0;
			busy <= 1'b0;
			done <= 1'b0;
			failed <= 1'b0;
			fail_code <= FAIL_NONE;
			device_id <= '0;
		end else begin
			if (frame_start) begin
				reply_pending <= reply_start;
				reply_seen <= 1'b0;
			end
			case (state)
				S_IDLE: begin
					if (start) begin
						busy <= 1'b1;
						done <= 1'b0;
						failed <= 1'b0;
						fail_code <= FAIL_NONE;
						device_id <= '0;
						nvm_phase <= 1'b0;
						state <= S_BREAK;
					end
				end
				S_BREAK: state <= S_BREAK_WAIT;
				S_BREAK_WAIT: begin
					if (double_break_done) begin
						state <= S_STATUSA;
					end
				end
				S_FRAME_WAIT: begin
					if (reply_done) begin
						reply_seen <= 1'b1;
						reply_ok_q <= reply_ack_ok;
					end
					if (!frame_busy && (!reply_pending || reply_seen || reply_done)) begin
						state <= wait_ret;
					end
				end
				S_DELAY_WAIT: begin
					if (delay_done) begin
						state <= wait_ret;
					end
				end
				S_STATUSA: begin
					wait_ret <= S_STATUSA_CHECK;
					state <= S_FRAME_WAIT;
				end
				S_STATUSA_CHECK: begin
					if (reply_bytes[7:0] == 8'h00) begin
						failed <= 1'b1;
						fail_code <= FAIL_STATUSA;
						busy <= 1'b0;
						state <= S_IDLE;
					end else begin
						state <= S_KEY;
					end
				end
				S_KEY: begin
					wait_ret <= S_KEY_STATUS;
					state <= S_FRAME_WAIT;
				end
				S_KEY_STATUS: begin
					wait_ret <= S_KEY_CHECK;
					state <= S_FRAME_WAIT;
				end
				S_KEY_CHECK: begin
					if (!key_ok) begin
						failed <= 1'b1;
						fail_code <= nvm_phase ? FAIL_KEY_NVMPROG : FAIL_KEY_CHIPERASE;
						busy <= 1'b0;
						state <= S_IDLE;
					end else begin
						state <= S_RESET_SET;
					end
				end
				S_RESET_SET: begin
					wait_ret <= S_RESET_DELAY;
					state <= S_FRAME_WAIT;
				end
				S_RESET_DELAY: begin
					wait_ret <= S_RESET_CLEAR;
					state <= S_DELAY_WAIT;
				end
				S_RESET_CLEAR: begin
					poll_cnt <= '0;
					wait_ret <= S_POLL;
					state <= S_FRAME_WAIT;
				end
				S_POLL: begin
					wait_ret <= S_POLL_CHECK;
					state <= S_FRAME_WAIT;
				end
				S_POLL_CHECK: begin
					if (poll_ready) begin
						nvm_phase <= 1'b1;
						state <= nvm_phase ? S_ID_PTR : S_KEY;
					end else if (poll_at_limit) begin
						failed <= 1'b1;
						fail_code <= FAIL_POLL_TIMEOUT;
						busy <= 1'b0;
						state <= S_IDLE;
					end else begin
						poll_cnt <= poll_cnt + 1'b1;
						wait_ret <= S_POLL;
						state <= S_DELAY_WAIT;
					end
				end
				S_ID_PTR: begin
					wait_ret <= S_ID_PTR_CHECK;
					state <= S_FRAME_WAIT;
				end
				S_ID_PTR_CHECK: begin
					if (!reply_ok_q) begin
						failed <= 1'b1;
						fail_code <= FAIL_NO_ACK;
						busy <= 1'b0;
						state <= S_IDLE;
					end else begin
						state <= S_ID_REPEAT;
					end
				end
				S_ID_REPEAT: begin
					wait_ret <= S_ID_LOAD;
					state <= S_FRAME_WAIT;
				end
				S_ID_LOAD: begin
					wait_ret <= S_ID_CAPTURE;
					state <= S_FRAME_WAIT;
				end
				S_ID_CAPTURE: begin
					device_id <= reply_bytes;
					done <= 1'b1;
					busy <= 1'b0;
					state <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

/* hw/updi_reply_collector.sv */
// Reads reply bytes from the UART RX FIFO, checks an ACK if asked and holds the bytes read
`timescale 1ns/1ps

module updi_reply_collector (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      reply_start,
	input  updi_prog_pkg::reply_len_t reply_len,
	input  logic                      reply_ack_only,
	input  updi_proto_pkg::byte_t     rx_data,
	output logic                      rx_rd_en,
	input  logic                      rx_empty,
	output logic                      reply_done,
	output logic                      reply_ack_ok,
	output updi_prog_pkg::device_id_t reply_bytes
);

	import updi_proto_pkg::*;
	import updi_prog_pkg::*;

	logic active;
	logic ack_only_q;
	// reads still to issue and bytes still to land
	reply_len_t req_left;
	reply_len_t recv_left;
	logic rd_valid;
	logic last_recv;

	assign rx_rd_en = active && (req_left != '0) && !rx_empty;
	assign last_recv = rd_valid && (recv_left == reply_len_t'(1));

	always_ff @(posedge clk) begin
		if (rst) begin
			active <= 1'b0;
			req_left <= '0;
			recv_left <= '0;
			rd_valid <= 1'b0;
			reply_done <= 1'b0;
		end else begin
			rd_valid <= rx_rd_en;
			reply_done <= last_recv;
			if (reply_start) begin
				active <= (reply_len != '0);
				req_left <= reply_len;
				recv_left <= reply_len;
			end else begin
				if (rx_rd_en) begin
					req_left <= req_left - 1'b1;
				end
				if (rd_valid) begin
					recv_left <= recv_left - 1'b1;
				end
				if (last_recv) begin
					active <= 1'b0;
				end
			end
		end
	end

	// first byte ends up on top after the last shift
	always_ff @(posedge clk) begin
		if (reply_start) begin
			ack_only_q <= reply_ack_only;
			reply_bytes <= '0;
		end else if (rd_valid) begin
			reply_bytes <= {reply_bytes[15:0], rx_data};
			if (last_recv) begin
				reply_ack_ok <= !ack_only_q || (rx_data == ACK_BYTE);
			end
		end
	end

endmodule

/* hw/updi_frame_builder.sv */
// Builds the SYNC-led byte stream of one UPDI frame and writes it into the UART TX FIFO
`timescale 1ns/1ps

module updi_frame_builder (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       frame_start,
	input  updi_prog_pkg::frame_kind_t frame_kind,
	input  updi_prog_pkg::cs_addr_t    frame_cs_addr,
	output logic                       frame_busy,
	output updi_proto_pkg::byte_t      tx_data,
	output logic                       tx_wr_en,
	input  logic                       tx_full
);

	import updi_proto_pkg::*;
	import updi_prog_pkg::*;

	frame_kind_t kind_q;
	cs_addr_t addr_q;
	logic [3:0] idx;
	logic last_byte;

	// total bytes on the wire, SYNC included
	function automatic logic [3:0] frame_len(frame_kind_t kind);
		case (kind)
			FRAME_LDCS:             return 4'd2;
			FRAME_STCS_RESET_SET:   return 4'd3;
			FRAME_STCS_RESET_CLEAR: return 4'd3;
			FRAME_KEY_CHIPERASE:    return 4'd10;
			FRAME_KEY_NVMPROG:      return 4'd10;
			FRAME_ST_PTR:           return 4'd4;
			FRAME_REPEAT:           return 4'd3;
			default:                return 4'd2;
		endcase
	endfunction

	function automatic byte_t frame_byte(frame_kind_t kind, cs_addr_t addr, logic [3:0] pos);
		logic [2:0] k;
		byte_t b;
		k = 3'(pos - 4'd2);
		b = SYNC_BYTE;
		if (pos != 4'd0) begin
			case (kind)
				FRAME_LDCS: b = OP_LDCS | {4'h0, addr};
				FRAME_STCS_RESET_SET:
					b = (pos == 4'd1) ? (OP_STCS | {4'h0, addr}) : RESET_SIGNATURE;
				FRAME_STCS_RESET_CLEAR:
					b = (pos == 4'd1) ? (OP_STCS | {4'h0, addr}) : 8'h00;
				FRAME_KEY_CHIPERASE:
					b = (pos == 4'd1) ? OP_KEY64 : KEY_CHIPERASE[8 * (7 - k) +: 8];
				FRAME_KEY_NVMPROG:
					b = (pos == 4'd1) ? OP_KEY64 : KEY_NVMPROG[8 * (7 - k) +: 8];
				FRAME_ST_PTR: begin
					// pointer address goes low byte first
					if (pos == 4'd1) begin
						b = OP_ST_PTR_WORD;
					end else if (pos == 4'd2) begin
						b = SIG_BASE_ADDR[7:0];
					end else begin
						b = SIG_BASE_ADDR[15:8];
					end
				end
				FRAME_REPEAT:
					b = (pos == 4'd1) ? OP_REPEAT_BYTE : byte_t'(DEVICE_ID_BYTES - 1);
				default: b = OP_LD_PTR_INC_BYTE;
			endcase
		end
		return b;
	endfunction

	assign tx_wr_en = frame_busy && !tx_full;
	assign tx_data = frame_byte(kind_q, addr_q, idx);
	assign last_byte = (idx == frame_len(kind_q) - 4'd1);

	always_ff @(posedge clk) begin
		if (frame_start) begin
			kind_q <= frame_kind;
			addr_q <= frame_cs_addr;
		end
	end

	// index only moves on an accepted write, so a full FIFO just holds the byte
	always_ff @(posedge clk) begin
		if (rst) begin
			frame_busy <= 1'b0;
			idx <= '0;
		end else if (frame_start) begin
			frame_busy <= 1'b1;
			idx <= '0;
		end else if (tx_wr_en) begin
			if (last_byte) begin
				frame_busy <= 1'b0;
			end else begin
				idx <= idx + 4'd1;
			end
		end
	end

endmodule

/* hw/updi_delay_timer.sv */
// Down-counter giving a done pulse a programmed number of cycles after its start pulse
`timescale 1ns/1ps

module updi_delay_timer (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      delay_start,
	input  updi_prog_pkg::delay_cnt_t delay_clks,
	output logic                      delay_done
);

	import updi_prog_pkg::*;

	delay_cnt_t count;
	logic running;

	// count reads 1 exactly delay_clks cycles after the start pulse
	assign delay_done = running && (count == delay_cnt_t'(1));

	always_ff @(posedge clk) begin
		if (rst) begin
			count <= '0;
			running <= 1'b0;
		end else if (delay_start) begin
			count <= delay_clks;
			running <= (delay_clks != '0);
		end else if (running) begin
			count <= count - 1'b1;
			if (delay_done) begin
				running <= 1'b0;
			end
		end
	end

endmodule

/* hw/updi_prog_pkg.sv */
// Session sequencer types: FSM states, frame kinds, fail codes and delay settings
package updi_prog_pkg;

	typedef enum logic [4:0] {
		S_IDLE,
		S_BREAK,
		S_BREAK_WAIT,
		S_FRAME_WAIT,
		S_DELAY_WAIT,
		S_STATUSA,
		S_STATUSA_CHECK,
		S_KEY,
		S_KEY_STATUS,
		S_KEY_CHECK,
		S_RESET_SET,
		S_RESET_DELAY,
		S_RESET_CLEAR,
		S_POLL,
		S_POLL_CHECK,
		S_ID_PTR,
		S_ID_PTR_CHECK,
		S_ID_REPEAT,
		S_ID_LOAD,
		S_ID_CAPTURE
	} seq_state_t;

	typedef enum logic [2:0] {
		FRAME_LDCS,
		FRAME_STCS_RESET_SET,
		FRAME_STCS_RESET_CLEAR,
		FRAME_KEY_CHIPERASE,
		FRAME_KEY_NVMPROG,
		FRAME_ST_PTR,
		FRAME_REPEAT,
		FRAME_LD_INC
	} frame_kind_t;

	typedef logic [3:0]  cs_addr_t;
	typedef logic [2:0]  fail_code_t;
	typedef logic [15:0] delay_cnt_t;
	typedef logic [1:0]  reply_len_t;
	typedef logic [23:0] device_id_t;

	localparam fail_code_t FAIL_NONE          = 3'd0;
	localparam fail_code_t FAIL_STATUSA       = 3'd1;
	localparam fail_code_t FAIL_KEY_CHIPERASE = 3'd2;
	localparam fail_code_t FAIL_KEY_NVMPROG   = 3'd3;
	localparam fail_code_t FAIL_POLL_TIMEOUT  = 3'd4;
	localparam fail_code_t FAIL_NO_ACK        = 3'd5;

	// settle time after a target reset and gap between status polls
	localparam delay_cnt_t RESET_DELAY_CLKS = 16'd100;
	localparam delay_cnt_t POLL_DELAY_CLKS  = 16'd100;
	localparam int POLL_LIMIT = 8;

endpackage

/* hw/updi_proto_pkg.sv */
// UPDI wire-level constants: opcodes, control register addresses, keys and status bits
package updi_proto_pkg;

	typedef logic [7:0] byte_t;

	// frame opener and instruction opcodes
	localparam byte_t SYNC_BYTE          = 8'h55;
	localparam byte_t OP_LDCS            = 8'h80;
	localparam byte_t OP_STCS            = 8'hC0;
	localparam byte_t OP_KEY64           = 8'hE0;
	localparam byte_t OP_REPEAT_BYTE     = 8'hA0;
	localparam byte_t OP_ST_PTR_WORD     = 8'h69;
	localparam byte_t OP_LD_PTR_INC_BYTE = 8'h24;
	localparam byte_t ACK_BYTE           = 8'h40;

	// control and status space addresses
	localparam logic [3:0] CS_STATUSA    = 4'h0;
	localparam logic [3:0] CS_KEY_STATUS = 4'h7;
	localparam logic [3:0] CS_RESET_REQ  = 4'h8;
	localparam logic [3:0] CS_SYS_STATUS = 4'hB;

	localparam byte_t RESET_SIGNATURE = 8'h59;

	// keys in wire order, the first byte on the wire sits in bits 63:56
	localparam logic [63:0] KEY_CHIPERASE = 64'h6573_6172_454D_564E;
	localparam logic [63:0] KEY_NVMPROG   = 64'h2067_6F72_504D_564E;

	// start of the signature row in data space
	localparam logic [15:0] SIG_BASE_ADDR = 16'h1100;

	// bit positions inside the status registers
	localparam int KEY_STATUS_CHIPERASE = 3;
	localparam int KEY_STATUS_NVMPROG   = 4;
	localparam int SYS_STATUS_LOCKED    = 0;
	localparam int SYS_STATUS_NVMPROG   = 3;

	localparam int DEVICE_ID_BYTES = 3;

endpackage
